// File: hdl/rs_eval_pkg.sv
// fixed rs(255,239) sizes only (2t = 16, gf(256) with 0x11d); log of zero is coded as 255
package rs_eval_pkg;

   localparam int sym_w = 8;                     // bits per field symbol
   localparam int n_syn = 16;                    // syndromes, 2t
   localparam int n_lam = 8;                     // locator coeffs above the constant 1
   localparam logic [8:0] gf_poly = 9'h11D;      // x^8+x^4+x^3+x^2+1

   typedef logic [sym_w-1:0] sym_t;

   localparam sym_t log_zero = 8'hFF;            // power code used for zero

   typedef sym_t [1:n_syn] syn_vec_t;            // index k holds S_k
   typedef sym_t [1:n_lam] lam_vec_t;            // index j holds L_j
   typedef sym_t [1:n_syn] omega_vec_t;          // index k holds omega coeff k

   typedef struct packed {
      syn_vec_t s;                               // syndromes, power form
      lam_vec_t l;                               // locator, power form
   } coef_log_t;

   typedef struct packed {
      sym_t p1;                                  // decimal form
      sym_t p3;                                  // power form from here on
      sym_t p5;
      sym_t p7;
   } phi_t;

   typedef enum logic {cap_idle, cap_convert} cap_state_t;
   typedef enum logic [1:0] {mac_idle, mac_run, mac_drain} mac_state_t;
   typedef enum logic [1:0] {out_idle, out_convert, out_done} out_state_t;

   ////////////////////////////////////////
   // table builders, elaboration time only
   ////////////////////////////////////////

   // alpha^i by repeated multiply by x
   function automatic sym_t gf_exp_at(int unsigned i);
      logic [8:0] acc;
      acc = 9'd1;
      for (int unsigned n = 0; n < i; n++)
      begin
         acc = acc << 1;
         if (acc[8])
            acc = acc ^ gf_poly;                 // reduce back into 8 bits
      end
      return acc[7:0];
   endfunction

   // walks alpha^0..alpha^254 and keeps the matching power
   function automatic sym_t gf_log_of(sym_t v);
      logic [8:0] p;
      sym_t r;
      p = 9'd1;
      r = log_zero;                              // zero never matches
      for (int n = 0; n < 255; n++)
      begin
         if (p[7:0] == v)
            r = sym_t'(n);
         p = p << 1;
         if (p[8])
            p = p ^ gf_poly;
      end
      return r;
   endfunction

endpackage

// File: hdl/gf_log_rom.sv
// one read port with one cycle of latency; the table is constant and has no reset
`timescale 1ns/1ps

module gf_log_rom import rs_eval_pkg::*;
(
   input  logic clk,
   input  sym_t addr,                            // decimal symbol
   output sym_t data                             // its power, 255 for zero
);

   sym_t rom [0:255];                            // decimal -> power table

   ////////////////////////////////////////
   // table fill
   ////////////////////////////////////////
   for (genvar i = 0; i < 256; i++)
   begin : g_fill
      assign rom[i] = gf_log_of(sym_t'(i));      // constant per entry
   end

   ////////////////////////////////////////
   // registered read
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      data <= rom[addr];
   end

endmodule

// File: hdl/coef_capture.sv
// inputs while busy are dropped without notice; logs_valid comes 26 cycles after lam_valid
`timescale 1ns/1ps

module coef_capture import rs_eval_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      syn_valid,                  // one-cycle pulse
   input  syn_vec_t  syn,                        // decimal syndromes
   input  logic      lam_valid,                  // one-cycle pulse, starts a run
   input  lam_vec_t  lam,                        // decimal locator
   input  logic      poly_ready,                 // end of run, frees the input side
   output logic      logs_valid,
   output coef_log_t logs,
   output syn_vec_t  syn_dec,
   output sym_t      l1_dec
);

   cap_state_t state;
   logic       busy;                             // from accepted lam_valid to poly_ready
   logic [4:0] cnt;                              // read step 0..24
   logic       accept;
   syn_vec_t   syn_q;
   lam_vec_t   lam_q;
   sym_t       rom_addr;
   sym_t       rom_data;

   assign accept  = lam_valid && !busy;
   assign syn_dec = syn_q;                       // seeds the accumulators
   assign l1_dec  = lam_q[1];                    // phi p1 stays decimal

   gf_log_rom log_rom_i (
      .clk  (clk),
      .addr (rom_addr),
      .data (rom_data)
   );

   // 16 syndromes first, then the 8 locator coeffs
   always_comb
   begin
      if (cnt < 5'd16)
         rom_addr = syn_q[cnt + 5'd1];
      else if (cnt < 5'd24)
         rom_addr = lam_q[cnt - 5'd15];
      else
         rom_addr = '0;                          // last step only collects data
   end

   ////////////////////////////////////////
   // control
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state      <= cap_idle;
         busy       <= 1'b0;
         cnt        <= '0;
         logs_valid <= 1'b0;
      end
      else
      begin
         logs_valid <= 1'b0;                     // pulse by default
         if (poly_ready)
            busy <= 1'b0;
         else if (accept)
            busy <= 1'b1;
         case (state)
            cap_idle:
            begin
               if (accept)
               begin
                  state <= cap_convert;
                  cnt   <= '0;
               end
            end
            cap_convert:
            begin
               if (cnt == 5'd24)
               begin
                  state      <= cap_idle;        // busy holds until poly_ready
                  logs_valid <= 1'b1;
               end
               else
                  cnt <= cnt + 5'd1;
            end
            default:
               state <= cap_idle;
         endcase
      end
   end

   ////////////////////////////////////////
   // payload
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (syn_valid && !busy)
         syn_q <= syn;                           // same-cycle lam_valid sees these
      if (accept)
         lam_q <= lam;
      if (state == cap_convert)
      begin
         // rom data trails the address by one step
         if (cnt >= 5'd1 && cnt <= 5'd16)
            logs.s[cnt] <= rom_data;
         else if (cnt >= 5'd17)
            logs.l[cnt - 5'd16] <= rom_data;
      end
   end

endmodule

// File: hdl/omega_mac.sv
// one product per cycle, 92 in all; omega_done comes 95 cycles after logs_valid
`timescale 1ns/1ps

module omega_mac import rs_eval_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       logs_valid,                // one-cycle pulse
   input  coef_log_t  logs,                      // power form operands
   input  syn_vec_t   syn_dec,                   // decimal seeds
   input  sym_t       l1_dec,
   output logic       omega_done,
   output omega_vec_t omega_dec,                 // accumulators, decimal
   output lam_vec_t   lam_logs,
   output sym_t       l1_out
);

   mac_state_t state;
   logic [4:0] k;                                // coefficient 2..16
   logic [3:0] j;                                // term 1..min(k-1,8)
   logic [3:0] j_last;
   logic       last_issue;
   sym_t       s_pow;
   sym_t       l_pow;
   logic [8:0] pow_sum;
   sym_t       prod;
   sym_t       alog [0:255];                     // power -> decimal

   // stage 1 registers
   logic       s1_valid;
   logic       s1_last;
   logic       s1_zero;                          // either operand was zero
   logic [4:0] s1_k;
   sym_t       s1_exp;
   // stage 2 marker
   logic       s2_last;

   for (genvar i = 0; i < 256; i++)
   begin : g_alog
      assign alog[i] = gf_exp_at(i);             // entry 255 wraps to 1, never used
   end

   assign j_last     = (k > 5'd8) ? 4'd8 : 4'(k - 5'd1);
   assign last_issue = (k == 5'd16) && (j == 4'd8);
   assign s_pow      = logs.s[k - 5'(j)];        // S_(k-j)
   assign l_pow      = logs.l[j];                // L_j
   assign pow_sum    = {1'b0, s_pow} + {1'b0, l_pow};
   assign prod       = s1_zero ? '0 : alog[s1_exp];

   ////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state      <= mac_idle;
         k          <= 5'd2;
         j          <= 4'd1;
         s1_valid   <= 1'b0;
         s1_last    <= 1'b0;
         s2_last    <= 1'b0;
         omega_done <= 1'b0;
      end
      else
      begin
         s1_valid   <= (state == mac_run);
         s1_last    <= (state == mac_run) && last_issue;
         s2_last    <= s1_valid && s1_last;      // last xor lands here
         omega_done <= s2_last;
         case (state)
            mac_idle:
            begin
               if (logs_valid)
               begin
                  state <= mac_run;
                  k     <= 5'd2;
                  j     <= 4'd1;
               end
            end
            mac_run:
            begin
               if (last_issue)
                  state <= mac_drain;            // two products still in flight
               else if (j == j_last)
               begin
                  j <= 4'd1;
                  k <= k + 5'd1;
               end
               else
                  j <= j + 4'd1;
            end
            mac_drain:
            begin
               if (s2_last)
                  state <= mac_idle;
            end
            default:
               state <= mac_idle;
         endcase
      end
   end

   ////////////////////////////////////////
   // log add and accumulate
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      s1_k    <= k;
      s1_exp  <= (pow_sum >= 9'd255) ? 8'(pow_sum - 9'd255) : pow_sum[7:0]; // mod 255
      s1_zero <= (s_pow == log_zero) || (l_pow == log_zero);
      if (logs_valid && state == mac_idle)
      begin
         omega_dec <= syn_dec;                   // coeff 1 stays S1
         lam_logs  <= logs.l;
         l1_out    <= l1_dec;
      end
      else if (s1_valid)
         omega_dec[s1_k] <= omega_dec[s1_k] ^ prod;
   end

endmodule

// File: hdl/poly_output.sv
// omega 1 and phi p1 stay decimal; poly_ready comes 20 cycles after omega_done
`timescale 1ns/1ps

module poly_output import rs_eval_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       omega_done,                // one-cycle pulse
   input  omega_vec_t omega_dec,
   input  lam_vec_t   lam_logs,                  // already power form
   input  sym_t       l1_out,
   output logic       poly_ready,                // one-cycle pulse
   output omega_vec_t omega,                     // held until the next result
   output phi_t       phi
);

   out_state_t state;
   logic [4:0] cnt;                              // read step 0..18
   sym_t       rom_addr;
   sym_t       rom_data;
   omega_vec_t om_q;                             // staging, outputs move at once
   phi_t       ph_q;

   gf_log_rom log_rom_i (
      .clk  (clk),
      .addr (rom_addr),
      .data (rom_data)
   );

   always_comb
   begin
      if (cnt < 5'd15)
         rom_addr = omega_dec[cnt + 5'd2];       // omega 2..16
      else
         rom_addr = '0;
   end

   ////////////////////////////////////////
   // control and outputs
   ////////////////////////////////////////
   always_ff @(posedge clk or posedge reset)
   begin
      if (reset)
      begin
         state      <= out_idle;
         cnt        <= '0;
         poly_ready <= 1'b0;
         omega      <= '0;
         phi        <= '0;
      end
      else
      begin
         poly_ready <= 1'b0;
         case (state)
            out_idle:
            begin
               if (omega_done)
               begin
                  state <= out_convert;
                  cnt   <= '0;
               end
            end
            out_convert:
            begin
               if (cnt == 5'd18)
               begin
                  omega      <= om_q;
                  phi        <= ph_q;
                  poly_ready <= 1'b1;
                  state      <= out_done;
               end
               else
                  cnt <= cnt + 5'd1;
            end
            default:
               state <= out_idle;               // out_done, one idle cycle
         endcase
      end
   end

   ////////////////////////////////////////
   // staging
   ////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (state == out_idle && omega_done)
      begin
         om_q[1] <= omega_dec[1];
         ph_q.p1 <= l1_out;
      end
      if (state == out_convert)
      begin
         if (cnt >= 5'd1 && cnt <= 5'd15)
            om_q[cnt + 5'd1] <= rom_data;        // one step behind the address
         // odd locator terms need no rom
         if (cnt == 5'd15)
            ph_q.p3 <= lam_logs[3];
         if (cnt == 5'd16)
            ph_q.p5 <= lam_logs[5];
         if (cnt == 5'd17)
            ph_q.p7 <= lam_logs[7];
      end
   end

endmodule

// File: hdl/omega_phy_top.sv
// valid inputs while a run is in progress are lost; lam_valid to poly_ready under 200 cycles
`timescale 1ns/1ps

module omega_phy_top import rs_eval_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   input  logic       syn_valid,
   input  syn_vec_t   syn,
   input  logic       lam_valid,
   input  lam_vec_t   lam,
   output logic       poly_ready,
   output omega_vec_t omega,
   output phi_t       phi
);

   logic       logs_valid;
   coef_log_t  logs;
   syn_vec_t   syn_dec;
   sym_t       l1_dec;
   logic       omega_done;
   omega_vec_t omega_dec;
   lam_vec_t   lam_logs;
   sym_t       l1_out;

   ////////////////////////////////////////
   // input side
   ////////////////////////////////////////
   coef_capture coef_capture_i (
      .clk        (clk),
      .reset      (reset),
      .syn_valid  (syn_valid),
      .syn        (syn),
      .lam_valid  (lam_valid),
      .lam        (lam),
      .poly_ready (poly_ready),                  // frees busy
      .logs_valid (logs_valid),
      .logs       (logs),
      .syn_dec    (syn_dec),
      .l1_dec     (l1_dec)
   );

   omega_mac omega_mac_i (
      .clk        (clk),
      .reset      (reset),
      .logs_valid (logs_valid),
      .logs       (logs),
      .syn_dec    (syn_dec),
      .l1_dec     (l1_dec),
      .omega_done (omega_done),
      .omega_dec  (omega_dec),
      .lam_logs   (lam_logs),
      .l1_out     (l1_out)
   );

   ////////////////////////////////////////
   // output side
   ////////////////////////////////////////
   poly_output poly_output_i (
      .clk        (clk),
      .reset      (reset),
      .omega_done (omega_done),
      .omega_dec  (omega_dec),
      .lam_logs   (lam_logs),
      .l1_out     (l1_out),
      .poly_ready (poly_ready),
      .omega      (omega),
      .phi        (phi)
   );

endmodule

// File: verification/omega_phy_tb.sv
// directed tests only; stops at the first mismatch, each run must finish within 200 cycles
`timescale 1ns/1ps

module omega_phy_tb import rs_eval_pkg::*;;

   localparam int run_limit   = 200;                         // cycles per run
   localparam int n_runs      = 12;
   localparam int cycle_limit = n_runs * run_limit + 100;

   logic       clk;
   logic       reset;
   logic       syn_valid;
   syn_vec_t   syn;
   logic       lam_valid;
   lam_vec_t   lam;
   logic       poly_ready;
   omega_vec_t omega;
   phi_t       phi;
   int         cycle_cnt = 0;

   omega_phy_top omega_phy_top_i (
      .clk        (clk),
      .reset      (reset),
      .syn_valid  (syn_valid),
      .syn        (syn),
      .lam_valid  (lam_valid),
      .lam        (lam),
      .poly_ready (poly_ready),
      .omega      (omega),
      .phi        (phi)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;                                // 40 ns period
   end

   ////////////////////////////////////////
   // reference model
   ////////////////////////////////////////
   function automatic sym_t gf_mul(sym_t a, sym_t b);
      logic [8:0] aa;
      sym_t       r;
      aa = {1'b0, a};
      r  = '0;
      for (int i = 0; i < 8; i++)
      begin
         if (b[i])
            r = r ^ aa[7:0];
         aa = aa << 1;
         if (aa[8])
            aa = aa ^ 9'h11D;                                // reduce mod x^8+x^4+x^3+x^2+1
      end
      return r;
   endfunction

   function automatic sym_t log_search(sym_t v);
      sym_t p;
      p = 8'd1;
      if (v == 8'd0)
         return 8'd255;                                      // zero has no power
      for (int n = 0; n < 255; n++)
      begin
         if (p == v)
            return sym_t'(n);
         p = gf_mul(p, 8'd2);
      end
      return 8'd255;
   endfunction

   // omega mod x^16, coeff 1 decimal and the rest as powers
   function automatic omega_vec_t expect_omega(syn_vec_t s, lam_vec_t l);
      omega_vec_t r;
      sym_t       acc;
      int         top;
      r[1] = s[1];
      for (int k = 2; k <= n_syn; k++)
      begin
         acc = s[k];
         top = (k - 1 < n_lam) ? k - 1 : n_lam;
         for (int j = 1; j <= top; j++)
            acc = acc ^ gf_mul(s[k - j], l[j]);
         r[k] = log_search(acc);
      end
      return r;
   endfunction

   function automatic phi_t expect_phi(lam_vec_t l);
      phi_t r;
      r.p1 = l[1];                                           // decimal
      r.p3 = log_search(l[3]);
      r.p5 = log_search(l[5]);
      r.p7 = log_search(l[7]);
      return r;
   endfunction

   ////////////////////////////////////////
   // checking helpers
   ////////////////////////////////////////
   task automatic report_fail(string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "stopping at first error");
   endtask

   task automatic check_sym(string name, sym_t got, sym_t expv);
      assert (got == expv)
      else
         report_fail($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                               $time, name, got, expv));
   endtask

   task automatic check_result(syn_vec_t s, lam_vec_t l);
      omega_vec_t eo;
      phi_t       ep;
      eo = expect_omega(s, l);
      ep = expect_phi(l);
      for (int k = 1; k <= n_syn; k++)
         check_sym($sformatf("omega[%0d]", k), omega[k], eo[k]);
      check_sym("phi.p1", phi.p1, ep.p1);
      check_sym("phi.p3", phi.p3, ep.p3);
      check_sym("phi.p5", phi.p5, ep.p5);
      check_sym("phi.p7", phi.p7, ep.p7);
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////
   task automatic send_syn(syn_vec_t s);
      @(posedge clk);
      syn_valid <= 1'b1;
      syn       <= s;
      @(posedge clk);
      syn_valid <= 1'b0;
   endtask

   task automatic send_both(syn_vec_t s, lam_vec_t l);
      @(posedge clk);
      syn_valid <= 1'b1;
      syn       <= s;
      lam_valid <= 1'b1;                                     // starts a run
      lam       <= l;
      @(posedge clk);
      syn_valid <= 1'b0;
      lam_valid <= 1'b0;
   endtask

   // waits for poly_ready, checks outputs there, then the pulse end
   task automatic finish_run(syn_vec_t s, lam_vec_t l);
      int n;
      n = 0;
      @(negedge clk);
      while (!poly_ready && n < run_limit)
      begin
         @(negedge clk);
         n = n + 1;
      end
      assert (poly_ready)
      else
         report_fail("poly_ready did not arrive within 200 cycles of the run start");
      check_result(s, l);
      @(negedge clk);
      check_sym("poly_ready", sym_t'(poly_ready), 8'd0);    // one-cycle pulse
   endtask

   task automatic random_syn(output syn_vec_t s);
      for (int k = 1; k <= n_syn; k++)
         s[k] = sym_t'($urandom);
   endtask

   task automatic random_lam(output lam_vec_t l);
      for (int j = 1; j <= n_lam; j++)
         l[j] = sym_t'($urandom);
   endtask

   ////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////
   task automatic test_reset_state();
      @(negedge clk);
      check_sym("poly_ready", sym_t'(poly_ready), 8'd0);
      for (int k = 1; k <= n_syn; k++)
         check_sym($sformatf("omega[%0d]", k), omega[k], 8'd0);
      check_sym("phi.p1", phi.p1, 8'd0);
      check_sym("phi.p3", phi.p3, 8'd0);
      check_sym("phi.p5", phi.p5, 8'd0);
      check_sym("phi.p7", phi.p7, 8'd0);
   endtask

   task automatic test_fixed_vector();
      syn_vec_t s;
      lam_vec_t l;
      for (int k = 1; k <= n_syn; k++)
         s[k] = sym_t'(k * 13 + 7);
      l    = '0;
      l[1] = 8'd1;                                           // lambda = 1 + x
      send_both(s, l);
      finish_run(s, l);
   endtask

   task automatic test_random_runs();
      syn_vec_t s;
      lam_vec_t l;
      for (int r = 0; r < 8; r++)
      begin
         random_syn(s);
         random_lam(l);
         send_both(s, l);
         finish_run(s, l);
      end
   endtask

   task automatic test_early_syndromes();
      syn_vec_t s;
      syn_vec_t junk;
      lam_vec_t l;
      random_syn(s);
      random_syn(junk);
      random_lam(l);
      send_syn(s);
      syn <= junk;                                           // bus changes, valid stays low
      repeat (3) @(posedge clk);
      lam_valid <= 1'b1;
      lam       <= l;
      @(posedge clk);
      lam_valid <= 1'b0;
      finish_run(s, l);
   endtask

   task automatic test_busy_ignored();
      syn_vec_t s;
      syn_vec_t s2;
      lam_vec_t l;
      lam_vec_t l2;
      random_syn(s);
      random_syn(s2);
      random_lam(l);
      random_lam(l2);
      send_both(s, l);
      repeat (5) @(posedge clk);
      send_both(s2, l2);                                     // lands while busy
      finish_run(s, l);
      repeat (run_limit)
      begin
         @(negedge clk);
         assert (!poly_ready)
         else
            report_fail("a second poly_ready came from inputs given while busy");
      end
   endtask

   task automatic test_zero_terms();
      syn_vec_t s;
      lam_vec_t l;
      s    = '0;
      s[1] = 8'h53;                                          // only S1 nonzero
      l    = '0;
      l[1] = 8'h21;
      l[2] = 8'h9A;
      l[4] = 8'h07;
      l[6] = 8'hC4;
      l[8] = 8'h3E;
      send_both(s, l);
      finish_run(s, l);
      check_sym("omega[4]", omega[4], 8'd255);               // S1*L3 is zero
      check_sym("omega[16]", omega[16], 8'd255);             // no terms reach it
      check_sym("phi.p3", phi.p3, 8'd255);
      check_sym("phi.p5", phi.p5, 8'd255);
      check_sym("phi.p7", phi.p7, 8'd255);
   endtask

   ////////////////////////////////////////
   // run control
   ////////////////////////////////////////
   initial
   begin
      while (cycle_cnt < cycle_limit)
      begin
         @(posedge clk);
         cycle_cnt = cycle_cnt + 1;
      end
      report_fail("run took longer than the cycle limit, simulation stopped");
   end

   initial
   begin
      void'($urandom(32'h24851e34));
      reset     <= 1'b1;
      syn_valid <= 1'b0;
      syn       <= '0;
      lam_valid <= 1'b0;
      lam       <= '0;
      repeat (10) @(posedge clk);
      reset <= 1'b0;
      test_reset_state();
      test_fixed_vector();
      test_random_runs();
      test_early_syndromes();
      test_busy_ignored();
      test_zero_terms();
      $display("Result: PASSED");
      $finish;
   end

endmodule

// File: all.f
hdl/rs_eval_pkg.sv
hdl/gf_log_rom.sv
hdl/coef_capture.sv
hdl/omega_mac.sv
hdl/poly_output.sv
hdl/omega_phy_top.sv
verification/omega_phy_tb.sv

// File: run.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f all.f --top-module omega_phy_tb -o omega_phy_sim

# the simulator exits non-zero on $fatal, the log decides the result
./obj_dir/omega_phy_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Result: FAILED" sim.log; then
   exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
   echo "simulation ended without a result line"
   exit 1
fi
exit 0
